// File: bench/tb_board_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_board_top;

  localparam int TIMEOUT_CYCLES = 20000;
  // Covers sync flops and hold count with margin
  localparam int RST_WAIT = board_pkg::RST_HOLD_CYCLES + 8;
  localparam int CPB = board_pkg::CLKS_PER_BIT;

  logic        clk;
  logic        i_arst_n;
  logic        i_pll_lock;
  logic        i_bus_wr;
  logic        i_bus_rd;
  logic [2:0]  i_bus_addr;
  logic [11:0] i_bus_wdata;
  logic [11:0] i_gpio;
  logic        i_uart_rd;
  logic [11:0] o_bus_rdata;
  logic        o_bus_rvalid;
  logic [11:0] o_gpio;
  logic [11:0] o_gpio_oe;
  logic        o_uart_td;
  logic [31:0] rng;
  int          cycle_cnt;

  board_top u_dut (
    .i_clk        (clk),
    .i_arst_n     (i_arst_n),
    .i_pll_lock   (i_pll_lock),
    .i_bus_wr     (i_bus_wr),
    .i_bus_rd     (i_bus_rd),
    .i_bus_addr   (i_bus_addr),
    .i_bus_wdata  (i_bus_wdata),
    .i_gpio       (i_gpio),
    .i_uart_rd    (i_uart_rd),
    .o_bus_rdata  (o_bus_rdata),
    .o_bus_rvalid (o_bus_rvalid),
    .o_gpio       (o_gpio),
    .o_gpio_oe    (o_gpio_oe),
    .o_uart_td    (o_uart_td)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [11:0] data);
    @(negedge clk);
    i_bus_wr    = 1'b1;
    i_bus_addr  = addr;
    i_bus_wdata = data;
    @(negedge clk);
    i_bus_wr    = 1'b0;
  endtask

  // Read data comes back with rvalid on the following cycle
  task automatic bus_read(input logic [2:0] addr, output logic [11:0] data);
    @(negedge clk);
    i_bus_rd   = 1'b1;
    i_bus_addr = addr;
    expect_equal(o_bus_rvalid, 1'b0, "rvalid before read strobe");
    @(negedge clk);
    i_bus_rd = 1'b0;
    expect_equal(o_bus_rvalid, 1'b1, "rvalid one cycle after read strobe");
    data = o_bus_rdata;
  endtask

  task automatic send_serial_byte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      i_uart_rd = frame[i];
      repeat (CPB - 1) @(negedge clk);
    end
  endtask

  // Polls the status word until any bit of the mask is set
  task automatic wait_status(input logic [11:0] mask, output logic [11:0] s);
    s = '0;
    while ((s & mask) == 0) begin
      bus_read(board_pkg::REG_UART_STAT, s);
    end
  endtask

  task automatic verify_reset_state();
    logic [11:0] d;
    repeat (3) @(negedge clk);
    rng = xorshift32(rng);
    bus_write(board_pkg::REG_GPIO_OUT, rng[11:0] | 12'h001);
    bus_write(board_pkg::REG_GPIO_DIR, rng[23:12] | 12'h001);
    repeat (RST_WAIT) @(negedge clk);
    expect_equal(o_gpio, 12'h000, "o_gpio after reset");
    expect_equal(o_gpio_oe, 12'h000, "o_gpio_oe after reset");
    expect_equal(o_uart_td, 1'b1, "o_uart_td idle after reset");
    bus_read(board_pkg::REG_UART_STAT, d);
    expect_equal(d, 12'h000, "status after reset");
    bus_read(board_pkg::REG_GPIO_OUT, d);
    expect_equal(d, 12'h000, "write during reset hold ignored");
  endtask

  task automatic gpio_register_access();
    logic [11:0] v;
    logic [11:0] dir;
    logic [11:0] d;
    repeat (4) begin
      rng = xorshift32(rng);
      v   = rng[11:0];
      dir = rng[27:16];
      bus_write(board_pkg::REG_GPIO_OUT, v);
      expect_equal(o_gpio, v, "o_gpio one cycle after write");
      bus_write(board_pkg::REG_GPIO_DIR, dir);
      expect_equal(o_gpio_oe, dir, "o_gpio_oe one cycle after write");
      bus_read(board_pkg::REG_GPIO_OUT, d);
      expect_equal(d, v, "GPIO_OUT readback");
      bus_read(board_pkg::REG_GPIO_DIR, d);
      expect_equal(d, dir, "GPIO_DIR readback");
    end
  endtask

  task automatic gpio_input_path();
    logic [11:0] d;
    rng = xorshift32(rng);
    @(negedge clk);
    i_gpio = rng[11:0];
    repeat (5) @(negedge clk);
    bus_read(board_pkg::REG_GPIO_IN, d);
    expect_equal(d, rng[11:0], "GPIO_IN readback");
    bus_read(3'd6, d);
    expect_equal(d, 12'h000, "unmapped address 6");
    bus_read(3'd7, d);
    expect_equal(d, 12'h000, "unmapped address 7");
  endtask

  task automatic uart_transmit_frame();
    logic [7:0]  b;
    logic [9:0]  frame;
    logic [11:0] s;
    int          i;
    rng   = xorshift32(rng);
    b     = rng[7:0];
    frame = {1'b1, b, 1'b0};
    bus_write(board_pkg::REG_UART_TX, {4'h0, b});
    // Move from half a cycle after the start edge to the first bit centre
    repeat (CPB / 2 - 1) @(negedge clk);
    for (i = 0; i < 10; i++) begin
      expect_equal(o_uart_td, frame[i], $sformatf("tx frame bit %0d", i));
      if (i == 3) begin
        // Dropped because the transmitter is busy
        bus_write(board_pkg::REG_UART_TX, {4'h0, ~b});
        repeat (CPB - 2) @(negedge clk);
      end else if (i == 5) begin
        bus_read(board_pkg::REG_UART_STAT, s);
        expect_equal(s, 12'h001, "status busy mid-frame");
        repeat (CPB - 2) @(negedge clk);
      end else if (i < 9) begin
        repeat (CPB) @(negedge clk);
      end
    end
    repeat (CPB) @(negedge clk);
    bus_read(board_pkg::REG_UART_STAT, s);
    expect_equal(s, 12'h000, "status idle after frame");
    expect_equal(o_uart_td, 1'b1, "line idle after frame");
  endtask

  task automatic uart_receive_bytes();
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic [11:0] s;
    rng = xorshift32(rng);
    b1  = rng[7:0];
    b2  = rng[15:8];
    send_serial_byte(b1);
    wait_status(12'h002, s);
    expect_equal(s, 12'h002, "status rx valid");
    bus_read(board_pkg::REG_UART_RX, s);
    expect_equal(s, {4'h0, b1}, "received byte");
    bus_read(board_pkg::REG_UART_STAT, s);
    expect_equal(s, 12'h000, "status cleared by rx read");
    // Two bytes with no read in between
    send_serial_byte(b1 ^ 8'h5a);
    send_serial_byte(b2);
    wait_status(12'h004, s);
    expect_equal(s, 12'h006, "status valid and overrun");
    bus_read(board_pkg::REG_UART_RX, s);
    expect_equal(s, {4'h0, b2}, "second byte kept on overrun");
    bus_read(board_pkg::REG_UART_STAT, s);
    expect_equal(s, 12'h000, "status cleared after overrun read");
  endtask

  task automatic pll_lock_loss();
    logic [11:0] s;
    rng = xorshift32(rng);
    bus_write(board_pkg::REG_GPIO_OUT, rng[11:0] | 12'h001);
    bus_write(board_pkg::REG_GPIO_DIR, rng[23:12] | 12'h001);
    send_serial_byte(rng[31:24]);
    wait_status(12'h002, s);
    // Lock drops inside the start bit, so the line has to return high
    bus_write(board_pkg::REG_UART_TX, {4'h0, rng[7:0]});
    expect_equal(o_uart_td, 1'b0, "start bit before lock loss");
    @(negedge clk);
    i_pll_lock = 1'b0;
    #1;
    expect_equal(o_gpio, 12'h000, "o_gpio at lock loss");
    expect_equal(o_gpio_oe, 12'h000, "o_gpio_oe at lock loss");
    expect_equal(o_uart_td, 1'b1, "o_uart_td at lock loss");
    repeat (4) @(negedge clk);
    i_pll_lock = 1'b1;
    repeat (RST_WAIT) @(negedge clk);
    bus_read(board_pkg::REG_GPIO_OUT, s);
    expect_equal(s, 12'h000, "GPIO_OUT after relock");
    bus_read(board_pkg::REG_GPIO_DIR, s);
    expect_equal(s, 12'h000, "GPIO_DIR after relock");
    bus_read(board_pkg::REG_UART_STAT, s);
    expect_equal(s, 12'h000, "status after relock");
  endtask

  initial begin
    i_arst_n    = 1'b0;
    i_pll_lock  = 1'b1;
    i_bus_wr    = 1'b0;
    i_bus_rd    = 1'b0;
    i_bus_addr  = '0;
    i_bus_wdata = '0;
    i_gpio      = '0;
    i_uart_rd   = 1'b1;
    rng         = 32'h758d54e5;
    cycle_cnt   = 0;
    repeat (4) @(negedge clk);
    i_arst_n = 1'b1;
    verify_reset_state();
    gpio_register_access();
    gpio_input_path();
    uart_transmit_frame();
    uart_receive_bytes();
    pll_lock_loss();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
verilog/board_pkg.sv
verilog/reset_gen.sv
verilog/gpio_ctrl.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/periph_bus.sv
verilog/board_top.sv
bench/tb_board_top.sv

// File: verilog/board_pkg.sv
`default_nettype none

package board_pkg;

  // Board pin and register bus widths
  localparam int GPIO_W = 12;
  localparam int DATA_W = 12;
  localparam int ADDR_W = 3;
  localparam int UART_W = 8;

  // Serial bit period in clock cycles
  localparam int CLKS_PER_BIT = 8;

  // Reset stretch once both reset sources are released
  localparam int RST_HOLD_CYCLES = 16;

  // Counter widths derived from the timing constants
  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_IDX_W = $clog2(UART_W);
  localparam int RST_CNT_W = $clog2(RST_HOLD_CYCLES);

  // Bit positions in the UART status word
  localparam int STAT_TX_BUSY    = 0;
  localparam int STAT_RX_VALID   = 1;
  localparam int STAT_RX_OVERRUN = 2;

  // Peripheral register map
  typedef enum logic [ADDR_W-1:0] {
    REG_GPIO_OUT  = 3'd0,
    REG_GPIO_DIR  = 3'd1,
    REG_GPIO_IN   = 3'd2,
    REG_UART_TX   = 3'd3,
    REG_UART_RX   = 3'd4,
    REG_UART_STAT = 3'd5
  } reg_addr_e;

  // Frame phases shared by transmitter and receiver
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

// File: verilog/board_top.sv
`timescale 1ns/1ns
`default_nettype none

module board_top (
  input  wire                          i_clk,
  input  wire                          i_arst_n,
  input  wire                          i_pll_lock,
  input  wire                          i_bus_wr,
  input  wire                          i_bus_rd,
  input  wire  [board_pkg::ADDR_W-1:0] i_bus_addr,
  input  wire  [board_pkg::DATA_W-1:0] i_bus_wdata,
  input  wire  [board_pkg::GPIO_W-1:0] i_gpio,
  input  wire                          i_uart_rd,
  output logic [board_pkg::DATA_W-1:0] o_bus_rdata,
  output logic                         o_bus_rvalid,
  output logic [board_pkg::GPIO_W-1:0] o_gpio,
  output logic [board_pkg::GPIO_W-1:0] o_gpio_oe,
  output logic                         o_uart_td
);

  logic                         w_rst_n;
  logic                         w_gpio_out_we;
  logic                         w_gpio_dir_we;
  logic                         w_tx_start;
  logic                         w_rx_ack;
  logic [board_pkg::DATA_W-1:0] w_wdata;
  logic [board_pkg::GPIO_W-1:0] w_gpio_out;
  logic [board_pkg::GPIO_W-1:0] w_gpio_dir;
  logic [board_pkg::GPIO_W-1:0] w_gpio_in;
  logic                         w_tx_busy;
  logic [board_pkg::UART_W-1:0] w_rx_data;
  logic                         w_rx_valid;
  logic                         w_rx_overrun;

  reset_gen u_reset_gen (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_pll_lock (i_pll_lock),
    .o_rst_n    (w_rst_n)
  );

  gpio_ctrl u_gpio_ctrl (
    .i_clk     (i_clk),
    .i_rst_n   (w_rst_n),
    .i_out_we  (w_gpio_out_we),
    .i_dir_we  (w_gpio_dir_we),
    .i_wdata   (w_wdata),
    .i_gpio    (i_gpio),
    .o_gpio    (w_gpio_out),
    .o_gpio_oe (w_gpio_dir),
    .o_gpio_in (w_gpio_in)
  );

  // Transmitter takes the low byte of the bus word
  uart_tx u_uart_tx (
    .i_clk   (i_clk),
    .i_rst_n (w_rst_n),
    .i_start (w_tx_start),
    .i_data  (w_wdata[board_pkg::UART_W-1:0]),
    .o_td    (o_uart_td),
    .o_busy  (w_tx_busy)
  );

  uart_rx u_uart_rx (
    .i_clk     (i_clk),
    .i_rst_n   (w_rst_n),
    .i_rd      (i_uart_rd),
    .i_ack     (w_rx_ack),
    .o_data    (w_rx_data),
    .o_valid   (w_rx_valid),
    .o_overrun (w_rx_overrun)
  );

  periph_bus u_periph_bus (
    .i_clk         (i_clk),
    .i_rst_n       (w_rst_n),
    .i_wr          (i_bus_wr),
    .i_rd          (i_bus_rd),
    .i_addr        (i_bus_addr),
    .i_wdata       (i_bus_wdata),
    .i_gpio_out    (w_gpio_out),
    .i_gpio_dir    (w_gpio_dir),
    .i_gpio_in     (w_gpio_in),
    .i_tx_busy     (w_tx_busy),
    .i_rx_data     (w_rx_data),
    .i_rx_valid    (w_rx_valid),
    .i_rx_overrun  (w_rx_overrun),
    .o_gpio_out_we (w_gpio_out_we),
    .o_gpio_dir_we (w_gpio_dir_we),
    .o_tx_start    (w_tx_start),
    .o_rx_ack      (w_rx_ack),
    .o_wdata       (w_wdata),
    .o_rdata       (o_bus_rdata),
    .o_rvalid      (o_bus_rvalid)
  );

  assign o_gpio    = w_gpio_out;
  assign o_gpio_oe = w_gpio_dir;

endmodule

`default_nettype wire

// File: verilog/gpio_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_ctrl (
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  input  wire                          i_out_we,
  input  wire                          i_dir_we,
  input  wire  [board_pkg::DATA_W-1:0] i_wdata,
  input  wire  [board_pkg::GPIO_W-1:0] i_gpio,
  output logic [board_pkg::GPIO_W-1:0] o_gpio,
  output logic [board_pkg::GPIO_W-1:0] o_gpio_oe,
  output logic [board_pkg::GPIO_W-1:0] o_gpio_in
);

  logic [board_pkg::GPIO_W-1:0] r_out;
  logic [board_pkg::GPIO_W-1:0] r_dir;
  logic [board_pkg::GPIO_W-1:0] r_in_meta;
  logic [board_pkg::GPIO_W-1:0] r_in_sync;

  // Output and direction registers, a 1 in r_dir drives the pin
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_out <= '0;
      r_dir <= '0;
    end else begin
      if (i_out_we) begin
        r_out <= i_wdata[board_pkg::GPIO_W-1:0];
      end
      if (i_dir_we) begin
        r_dir <= i_wdata[board_pkg::GPIO_W-1:0];
      end
    end
  end

  // Pins come from the board domain, two flops before use
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_in_meta <= '0;
      r_in_sync <= '0;
    end else begin
      r_in_meta <= i_gpio;
      r_in_sync <= r_in_meta;
    end
  end

  assign o_gpio    = r_out;
  assign o_gpio_oe = r_dir;
  assign o_gpio_in = r_in_sync;

endmodule

`default_nettype wire

// File: verilog/periph_bus.sv
`timescale 1ns/1ns
`default_nettype none

module periph_bus (
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  input  wire                          i_wr,
  input  wire                          i_rd,
  input  wire  [board_pkg::ADDR_W-1:0] i_addr,
  input  wire  [board_pkg::DATA_W-1:0] i_wdata,
  input  wire  [board_pkg::GPIO_W-1:0] i_gpio_out,
  input  wire  [board_pkg::GPIO_W-1:0] i_gpio_dir,
  input  wire  [board_pkg::GPIO_W-1:0] i_gpio_in,
  input  wire                          i_tx_busy,
  input  wire  [board_pkg::UART_W-1:0] i_rx_data,
  input  wire                          i_rx_valid,
  input  wire                          i_rx_overrun,
  output logic                         o_gpio_out_we,
  output logic                         o_gpio_dir_we,
  output logic                         o_tx_start,
  output logic                         o_rx_ack,
  output logic [board_pkg::DATA_W-1:0] o_wdata,
  output logic [board_pkg::DATA_W-1:0] o_rdata,
  output logic                         o_rvalid
);

  board_pkg::reg_addr_e         w_addr;
  logic [board_pkg::DATA_W-1:0] w_rdata;
  logic [board_pkg::DATA_W-1:0] r_rdata;
  logic                         r_rvalid;

  // Addresses 6 and 7 match no case below
  assign w_addr = board_pkg::reg_addr_e'(i_addr);

  assign o_gpio_out_we = i_wr && (w_addr == board_pkg::REG_GPIO_OUT);
  assign o_gpio_dir_we = i_wr && (w_addr == board_pkg::REG_GPIO_DIR);
  assign o_tx_start    = i_wr && (w_addr == board_pkg::REG_UART_TX);
  // Reading the RX byte clears the flags on the edge that returns it
  assign o_rx_ack      = i_rd && (w_addr == board_pkg::REG_UART_RX);
  assign o_wdata       = i_wdata;

  always_comb begin
    w_rdata = '0;
    case (w_addr)
      board_pkg::REG_GPIO_OUT: w_rdata = i_gpio_out;
      board_pkg::REG_GPIO_DIR: w_rdata = i_gpio_dir;
      board_pkg::REG_GPIO_IN:  w_rdata = i_gpio_in;
      board_pkg::REG_UART_RX:  w_rdata[board_pkg::UART_W-1:0] = i_rx_data;
      board_pkg::REG_UART_STAT: begin
        w_rdata[board_pkg::STAT_TX_BUSY]    = i_tx_busy;
        w_rdata[board_pkg::STAT_RX_VALID]   = i_rx_valid;
        w_rdata[board_pkg::STAT_RX_OVERRUN] = i_rx_overrun;
      end
      default: w_rdata = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rd) begin
      r_rdata <= w_rdata;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_rvalid <= 1'b0;
    end else begin
      r_rvalid <= i_rd;
    end
  end

  assign o_rdata  = r_rdata;
  assign o_rvalid = r_rvalid;

endmodule

`default_nettype wire

// File: verilog/reset_gen.sv
`timescale 1ns/1ns
`default_nettype none

module reset_gen (
  input  wire  i_clk,
  input  wire  i_arst_n,
  input  wire  i_pll_lock,
  output logic o_rst_n
);

  logic                            w_arst_n;
  logic [1:0]                      r_sync;
  logic [board_pkg::RST_CNT_W-1:0] r_hold_cnt;
  logic                            r_rst_n;

  // Either source pulls reset at once, lock loss included
  assign w_arst_n = i_arst_n & i_pll_lock;

  always_ff @(posedge i_clk or negedge w_arst_n) begin
    if (!w_arst_n) begin
      r_sync     <= '0;
      r_hold_cnt <= '0;
      r_rst_n    <= 1'b0;
    end else begin
      // Release passes through two flops first
      r_sync <= {r_sync[0], 1'b1};
      if (r_sync[1] && !r_rst_n) begin
        if (r_hold_cnt == board_pkg::RST_CNT_W'(board_pkg::RST_HOLD_CYCLES - 1)) begin
          r_rst_n <= 1'b1;
        end else begin
          r_hold_cnt <= r_hold_cnt + 1'b1;
        end
      end
    end
  end

  assign o_rst_n = r_rst_n;

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  input  wire                          i_rd,
  input  wire                          i_ack,
  output logic [board_pkg::UART_W-1:0] o_data,
  output logic                         o_valid,
  output logic                         o_overrun
);

  board_pkg::uart_state_e          r_state;
  logic [2:0]                      r_sync;
  logic [board_pkg::BIT_CNT_W-1:0] r_cnt;
  logic [board_pkg::BIT_IDX_W-1:0] r_idx;
  logic [board_pkg::UART_W-1:0]    r_shift;
  logic                            w_line;
  logic                            w_fall;
  logic                            w_half;
  logic                            w_bit_end;
  logic                            w_done;

  // Line idles high, so the synchronizer comes out of reset at 1
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_sync <= '1;
    end else begin
      r_sync <= {r_sync[1:0], i_rd};
    end
  end

  assign w_line    = r_sync[1];
  assign w_fall    = r_sync[2] & ~r_sync[1];
  assign w_half    = (r_cnt == board_pkg::BIT_CNT_W'(board_pkg::CLKS_PER_BIT / 2 - 1));
  assign w_bit_end = (r_cnt == board_pkg::BIT_CNT_W'(board_pkg::CLKS_PER_BIT - 1));
  // Frame counts only with a good stop bit
  assign w_done    = (r_state == board_pkg::UART_STOP) && w_bit_end && w_line;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state <= board_pkg::UART_IDLE;
      r_cnt   <= '0;
      r_idx   <= '0;
    end else begin
      r_cnt <= r_cnt + 1'b1;
      case (r_state)
        board_pkg::UART_IDLE: begin
          r_cnt <= '0;
          if (w_fall) begin
            r_state <= board_pkg::UART_START;
          end
        end
        board_pkg::UART_START: begin
          if (w_half) begin
            r_cnt <= '0;
            r_idx <= '0;
            // Line back high at mid start is taken as a glitch
            r_state <= w_line ? board_pkg::UART_IDLE : board_pkg::UART_DATA;
          end
        end
        board_pkg::UART_DATA: begin
          if (w_bit_end) begin
            r_cnt <= '0;
            if (r_idx == board_pkg::BIT_IDX_W'(board_pkg::UART_W - 1)) begin
              r_state <= board_pkg::UART_STOP;
            end else begin
              r_idx <= r_idx + 1'b1;
            end
          end
        end
        board_pkg::UART_STOP: begin
          if (w_bit_end) begin
            r_cnt   <= '0;
            r_state <= board_pkg::UART_IDLE;
          end
        end
        default: r_state <= board_pkg::UART_IDLE;
      endcase
    end
  end

  // Bits arrive LSB first and enter from the top
  always_ff @(posedge i_clk) begin
    if (r_state == board_pkg::UART_DATA && w_bit_end) begin
      r_shift <= {w_line, r_shift[board_pkg::UART_W-1:1]};
    end
    if (w_done) begin
      o_data <= r_shift;
    end
  end

  // New byte wins over an ack on the same edge
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid   <= 1'b0;
      o_overrun <= 1'b0;
    end else if (w_done) begin
      o_valid   <= 1'b1;
      o_overrun <= o_valid & ~i_ack;
    end else if (i_ack) begin
      o_valid   <= 1'b0;
      o_overrun <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  input  wire                          i_start,
  input  wire  [board_pkg::UART_W-1:0] i_data,
  output logic                         o_td,
  output logic                         o_busy
);

  board_pkg::uart_state_e          r_state;
  logic [board_pkg::BIT_CNT_W-1:0] r_cnt;
  logic [board_pkg::BIT_IDX_W-1:0] r_idx;
  logic [board_pkg::UART_W-1:0]    r_shift;
  logic                            r_td;
  logic                            w_bit_end;
  logic                            w_load;

  assign w_bit_end = (r_cnt == board_pkg::BIT_CNT_W'(board_pkg::CLKS_PER_BIT - 1));
  // Start is only taken when idle, so a write while busy is lost
  assign w_load    = (r_state == board_pkg::UART_IDLE) && i_start;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state <= board_pkg::UART_IDLE;
      r_cnt   <= '0;
      r_idx   <= '0;
      r_td    <= 1'b1;
    end else begin
      r_cnt <= w_bit_end ? '0 : r_cnt + 1'b1;
      case (r_state)
        board_pkg::UART_IDLE: begin
          r_cnt <= '0;
          if (i_start) begin
            r_state <= board_pkg::UART_START;
            r_td    <= 1'b0;
          end
        end
        board_pkg::UART_START: begin
          if (w_bit_end) begin
            r_state <= board_pkg::UART_DATA;
            r_idx   <= '0;
            r_td    <= r_shift[0];
          end
        end
        board_pkg::UART_DATA: begin
          if (w_bit_end) begin
            if (r_idx == board_pkg::BIT_IDX_W'(board_pkg::UART_W - 1)) begin
              r_state <= board_pkg::UART_STOP;
              r_td    <= 1'b1;
            end else begin
              r_idx <= r_idx + 1'b1;
              r_td  <= r_shift[1];
            end
          end
        end
        board_pkg::UART_STOP: begin
          if (w_bit_end) begin
            r_state <= board_pkg::UART_IDLE;
          end
        end
        default: r_state <= board_pkg::UART_IDLE;
      endcase
    end
  end

  // LSB first, next bit moves down at each data bit boundary
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_shift <= i_data;
    end else if (r_state == board_pkg::UART_DATA && w_bit_end) begin
      r_shift <= r_shift >> 1;
    end
  end

  assign o_td   = r_td;
  assign o_busy = (r_state != board_pkg::UART_IDLE);

endmodule

`default_nettype wire
